/* include/wed_layout.svh */
`ifndef WED_LAYOUT_SVH
`define WED_LAYOUT_SVH

// Descriptor layout inside beat 0 of the fetched line
// Each value is the bit position of the field LSB

// Status word written back by the host
`define WED_STATUS_OFFSET 0

// Element counts
`define WED_VERTEX_COUNT_OFFSET 64
`define WED_EDGE_COUNT_OFFSET 128

// Host array base addresses, cache-line aligned
`define WED_VERTEX_ARRAY_OFFSET 192
`define WED_EDGE_ARRAY_OFFSET 256
`define WED_RESULT_ARRAY_OFFSET 320

// First bit past the last field
`define WED_LAYOUT_END 384

`endif

/* logic/wed_pkg.sv */
`default_nettype none

package wed_pkg;

  // Bus widths
  localparam int beat_width = 512;
  localparam int addr_width = 64;
  localparam int tag_width = 8;
  localparam int index_width = 6;  // Beat number within a line
  localparam int size_width = 12;

  // One cache line per descriptor read
  localparam logic [size_width-1:0] line_bytes = 12'd128;

  // Array addresses must sit on a 128-byte line boundary
  localparam int align_bits = 7;

  // Descriptor field widths
  localparam int status_width = 64;
  localparam int vertex_count_width = 64;
  localparam int edge_count_width = 64;
  localparam int vertex_array_width = 64;
  localparam int edge_array_width = 64;
  localparam int result_array_width = 64;

  // Command tags
  localparam logic [tag_width-1:0] wed_tag = 8'h2a;
  localparam logic [tag_width-1:0] invalid_tag = 8'hff;  // No command held

  // Fetch FSM states
  typedef enum logic [2:0] {
    wed_reset,
    wed_idle,
    wed_cmd_req,
    wed_cmd_release,
    wed_collect,
    wed_line_done,
    wed_fail,
    wed_hold
  } wed_state;

  // Bus command opcodes
  typedef enum logic [12:0] {
    invalid_cmd = 13'h0000,
    read_cl_na  = 13'h0a00  // Read cache line, no allocate
  } command_code;

  // Host response codes
  typedef enum logic [7:0] {
    done   = 8'h00,
    failed = 8'h01
  } response_code;

  // Descriptor check result
  typedef enum logic [1:0] {
    err_none,
    err_response,
    err_align,
    err_empty
  } wed_error;

endpackage

`default_nettype wire

/* logic/wed_control.sv */
`timescale 1ns/1ps
`default_nettype none

module wed_control #(
  parameter int line_beats = 2
) (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  enable,
  input  logic [wed_pkg::addr_width-1:0]        wed_address,
  // Command toward the host
  output logic                                  command_req,
  output wed_pkg::command_code                  command_code,
  output logic [wed_pkg::addr_width-1:0]        command_address,
  output logic [wed_pkg::tag_width-1:0]         command_tag,
  output logic [wed_pkg::size_width-1:0]        command_size,
  input  logic                                  command_ack,
  // Data beats from the host
  input  logic                                  beat_valid,
  input  logic [wed_pkg::tag_width-1:0]         beat_tag,
  input  logic [wed_pkg::index_width-1:0]       beat_index,
  input  logic [wed_pkg::beat_width-1:0]        beat_data,
  // Host response
  input  logic                                  response_valid,
  input  logic [wed_pkg::tag_width-1:0]         response_tag,
  input  wed_pkg::response_code                 response_code,
  // From the result block
  input  logic                                  wed_released,
  // Assembled line toward decode
  output logic                                  line_valid,
  output logic [line_beats*wed_pkg::beat_width-1:0] line_data,
  output logic                                  line_failed
);

  import wed_pkg::*;

  wed_state state;
  wed_state next_state;
  logic     beat_hit;
  logic     response_hit;

  // Beats may arrive as soon as the host has taken the command
  assign beat_hit = beat_valid && (beat_tag == wed_tag) &&
                    ((state == wed_cmd_release) || (state == wed_collect));

  // Foreign responses are ignored
  assign response_hit = response_valid && (response_tag == wed_tag) &&
                        (state == wed_collect);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= wed_reset;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      wed_reset: begin
        next_state = wed_idle;
      end
      wed_idle: begin
        if (enable) begin
          next_state = wed_cmd_req;
        end
      end
      wed_cmd_req: begin
        if (command_ack) begin
          next_state = wed_cmd_release;
        end
      end
      wed_cmd_release: begin
        if (!command_ack) begin  // Four-phase handshake complete
          next_state = wed_collect;
        end
      end
      wed_collect: begin
        if (response_hit) begin
          next_state = (response_code == done) ? wed_line_done : wed_fail;
        end
      end
      wed_line_done, wed_fail: begin
        next_state = wed_hold;
      end
      wed_hold: begin
        if (wed_released) begin  // Consumer has taken the descriptor
          next_state = wed_idle;
        end
      end
      default: begin
        next_state = wed_reset;
      end
    endcase
  end

  // Command fields stay put while req is high
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_req     <= 1'b0;
      command_code    <= invalid_cmd;
      command_address <= '0;
      command_tag     <= invalid_tag;
      command_size    <= '0;
    end else if ((state == wed_idle) && (next_state == wed_cmd_req)) begin
      command_req     <= 1'b1;
      command_code    <= read_cl_na;
      command_address <= wed_address;
      command_tag     <= wed_tag;
      command_size    <= line_bytes;
    end else if ((state == wed_cmd_req) && command_ack) begin
      command_req     <= 1'b0;  // Drop req once ack seen
    end else if ((state == wed_hold) && wed_released) begin
      command_code    <= invalid_cmd;
      command_tag     <= invalid_tag;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      line_valid  <= 1'b0;
      line_failed <= 1'b0;
    end else begin
      line_valid  <= response_hit;
      line_failed <= response_hit && (response_code != done);
    end
  end

  // Each beat lands in the slot named by its index
  always_ff @(posedge clock) begin
    for (int i = 0; i < line_beats; i++) begin
      if (beat_hit && (beat_index == index_width'(i))) begin
        line_data[i*beat_width +: beat_width] <= beat_data;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/wed_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wed_layout.svh"

module wed_decode (
  input  logic                                   clock,
  input  logic                                   rstn,
  input  logic                                   line_valid,
  input  logic [wed_pkg::beat_width-1:0]         line_data,  // Header beat
  input  logic                                   line_failed,
  output logic                                   decoded_valid,
  output logic [wed_pkg::status_width-1:0]       decoded_status,
  output logic [wed_pkg::vertex_count_width-1:0] decoded_vertex_count,
  output logic [wed_pkg::edge_count_width-1:0]   decoded_edge_count,
  output logic [wed_pkg::vertex_array_width-1:0] decoded_vertex_array,
  output logic [wed_pkg::edge_array_width-1:0]   decoded_edge_array,
  output logic [wed_pkg::result_array_width-1:0] decoded_result_array,
  output wed_pkg::wed_error                      decoded_error
);

  import wed_pkg::*;

  logic [status_width-1:0]       status_field;
  logic [vertex_count_width-1:0] vertex_count_field;
  logic [edge_count_width-1:0]   edge_count_field;
  logic [vertex_array_width-1:0] vertex_array_field;
  logic [edge_array_width-1:0]   edge_array_field;
  logic [result_array_width-1:0] result_array_field;
  logic                          misaligned;
  wed_error                      error_next;

  assign status_field       = line_data[`WED_STATUS_OFFSET +: status_width];
  assign vertex_count_field = line_data[`WED_VERTEX_COUNT_OFFSET +: vertex_count_width];
  assign edge_count_field   = line_data[`WED_EDGE_COUNT_OFFSET +: edge_count_width];
  assign vertex_array_field = line_data[`WED_VERTEX_ARRAY_OFFSET +: vertex_array_width];
  assign edge_array_field   = line_data[`WED_EDGE_ARRAY_OFFSET +: edge_array_width];
  assign result_array_field = line_data[`WED_RESULT_ARRAY_OFFSET +: result_array_width];

  // Any array base off a line boundary
  assign misaligned = (vertex_array_field[align_bits-1:0] != '0) ||
                      (edge_array_field[align_bits-1:0] != '0) ||
                      (result_array_field[align_bits-1:0] != '0);

  always_comb begin
    if (line_failed) begin
      error_next = err_response;
    end else if (misaligned) begin
      error_next = err_align;
    end else if (vertex_count_field == '0) begin
      error_next = err_empty;
    end else begin
      error_next = err_none;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      decoded_valid <= 1'b0;
      decoded_error <= err_none;
    end else begin
      decoded_valid <= line_valid;
      if (line_valid) begin
        decoded_error <= error_next;
      end
    end
  end

  // A failed read carries no usable fields
  always_ff @(posedge clock) begin
    if (line_valid) begin
      decoded_status       <= line_failed ? '0 : status_field;
      decoded_vertex_count <= line_failed ? '0 : vertex_count_field;
      decoded_edge_count   <= line_failed ? '0 : edge_count_field;
      decoded_vertex_array <= line_failed ? '0 : vertex_array_field;
      decoded_edge_array   <= line_failed ? '0 : edge_array_field;
      decoded_result_array <= line_failed ? '0 : result_array_field;
    end
  end

endmodule

`default_nettype wire

/* logic/wed_result.sv */
`timescale 1ns/1ps
`default_nettype none

module wed_result (
  input  logic                                   clock,
  input  logic                                   rstn,
  input  logic                                   decoded_valid,
  input  logic [wed_pkg::status_width-1:0]       decoded_status,
  input  logic [wed_pkg::vertex_count_width-1:0] decoded_vertex_count,
  input  logic [wed_pkg::edge_count_width-1:0]   decoded_edge_count,
  input  logic [wed_pkg::vertex_array_width-1:0] decoded_vertex_array,
  input  logic [wed_pkg::edge_array_width-1:0]   decoded_edge_array,
  input  logic [wed_pkg::result_array_width-1:0] decoded_result_array,
  input  wed_pkg::wed_error                      decoded_error,
  input  logic                                   wed_ack,
  output logic                                   wed_req,
  output wed_pkg::wed_error                      wed_error_code,
  output logic [wed_pkg::status_width-1:0]       wed_status,
  output logic [wed_pkg::vertex_count_width-1:0] wed_vertex_count,
  output logic [wed_pkg::edge_count_width-1:0]   wed_edge_count,
  output logic [wed_pkg::vertex_array_width-1:0] wed_vertex_array,
  output logic [wed_pkg::edge_array_width-1:0]   wed_edge_array,
  output logic [wed_pkg::result_array_width-1:0] wed_result_array,
  output logic                                   wed_released
);

  import wed_pkg::*;

  logic release_pending;  // Ack seen, waiting for it to fall
  logic accept;

  // Only take a new descriptor when no handshake is in flight
  assign accept = decoded_valid && !wed_req && !release_pending;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_req         <= 1'b0;
      release_pending <= 1'b0;
      wed_released    <= 1'b0;
    end else begin
      wed_released <= 1'b0;
      if (accept) begin
        wed_req <= 1'b1;
      end else if (wed_req && wed_ack) begin
        wed_req         <= 1'b0;
        release_pending <= 1'b1;
      end else if (release_pending && !wed_ack) begin
        release_pending <= 1'b0;
        wed_released    <= 1'b1;  // One-cycle pulse to control
      end
    end
  end

  // Descriptor held until the next one is accepted
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_error_code   <= err_none;
      wed_status       <= '0;
      wed_vertex_count <= '0;
      wed_edge_count   <= '0;
      wed_vertex_array <= '0;
      wed_edge_array   <= '0;
      wed_result_array <= '0;
    end else if (accept) begin
      wed_error_code   <= decoded_error;
      wed_status       <= decoded_status;
      wed_vertex_count <= decoded_vertex_count;
      wed_edge_count   <= decoded_edge_count;
      wed_vertex_array <= decoded_vertex_array;
      wed_edge_array   <= decoded_edge_array;
      wed_result_array <= decoded_result_array;
    end
  end

endmodule

`default_nettype wire

/* logic/wed_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module wed_fetch_top (
  input  logic                                   clock,
  input  logic                                   rstn,
  input  logic                                   enable,
  input  logic [wed_pkg::addr_width-1:0]         wed_address,
  output logic                                   command_req,
  output wed_pkg::command_code                   command_code,
  output logic [wed_pkg::addr_width-1:0]         command_address,
  output logic [wed_pkg::tag_width-1:0]          command_tag,
  output logic [wed_pkg::size_width-1:0]         command_size,
  input  logic                                   command_ack,
  input  logic                                   beat_valid,
  input  logic [wed_pkg::tag_width-1:0]          beat_tag,
  input  logic [wed_pkg::index_width-1:0]        beat_index,
  input  logic [wed_pkg::beat_width-1:0]         beat_data,
  input  logic                                   response_valid,
  input  logic [wed_pkg::tag_width-1:0]          response_tag,
  input  wed_pkg::response_code                  response_code,
  output logic                                   wed_req,
  input  logic                                   wed_ack,
  output wed_pkg::wed_error                      wed_error_code,
  output logic [wed_pkg::status_width-1:0]       wed_status,
  output logic [wed_pkg::vertex_count_width-1:0] wed_vertex_count,
  output logic [wed_pkg::edge_count_width-1:0]   wed_edge_count,
  output logic [wed_pkg::vertex_array_width-1:0] wed_vertex_array,
  output logic [wed_pkg::edge_array_width-1:0]   wed_edge_array,
  output logic [wed_pkg::result_array_width-1:0] wed_result_array
);

  import wed_pkg::*;

  localparam int line_beats = 2;  // One 128-byte line

  logic                            line_valid;
  logic [line_beats*beat_width-1:0] line_data;
  logic                            line_failed;
  logic                            decoded_valid;
  logic [status_width-1:0]         decoded_status;
  logic [vertex_count_width-1:0]   decoded_vertex_count;
  logic [edge_count_width-1:0]     decoded_edge_count;
  logic [vertex_array_width-1:0]   decoded_vertex_array;
  logic [edge_array_width-1:0]     decoded_edge_array;
  logic [result_array_width-1:0]   decoded_result_array;
  wed_error                        decoded_error;
  logic                            wed_released;

  wed_control #(
    .line_beats (line_beats)
  ) control0 (
    .clock           (clock),
    .rstn            (rstn),
    .enable          (enable),
    .wed_address     (wed_address),
    .command_req     (command_req),
    .command_code    (command_code),
    .command_address (command_address),
    .command_tag     (command_tag),
    .command_size    (command_size),
    .command_ack     (command_ack),
    .beat_valid      (beat_valid),
    .beat_tag        (beat_tag),
    .beat_index      (beat_index),
    .beat_data       (beat_data),
    .response_valid  (response_valid),
    .response_tag    (response_tag),
    .response_code   (response_code),
    .wed_released    (wed_released),
    .line_valid      (line_valid),
    .line_data       (line_data),
    .line_failed     (line_failed)
  );

  // Only beat 0 carries the descriptor
  wed_decode decode0 (
    .clock                (clock),
    .rstn                 (rstn),
    .line_valid           (line_valid),
    .line_data            (line_data[beat_width-1:0]),
    .line_failed          (line_failed),
    .decoded_valid        (decoded_valid),
    .decoded_status       (decoded_status),
    .decoded_vertex_count (decoded_vertex_count),
    .decoded_edge_count   (decoded_edge_count),
    .decoded_vertex_array (decoded_vertex_array),
    .decoded_edge_array   (decoded_edge_array),
    .decoded_result_array (decoded_result_array),
    .decoded_error        (decoded_error)
  );

  wed_result result0 (
    .clock                (clock),
    .rstn                 (rstn),
    .decoded_valid        (decoded_valid),
    .decoded_status       (decoded_status),
    .decoded_vertex_count (decoded_vertex_count),
    .decoded_edge_count   (decoded_edge_count),
    .decoded_vertex_array (decoded_vertex_array),
    .decoded_edge_array   (decoded_edge_array),
    .decoded_result_array (decoded_result_array),
    .decoded_error        (decoded_error),
    .wed_ack              (wed_ack),
    .wed_req              (wed_req),
    .wed_error_code       (wed_error_code),
    .wed_status           (wed_status),
    .wed_vertex_count     (wed_vertex_count),
    .wed_edge_count       (wed_edge_count),
    .wed_vertex_array     (wed_vertex_array),
    .wed_edge_array       (wed_edge_array),
    .wed_result_array     (wed_result_array),
    .wed_released         (wed_released)
  );

endmodule

`default_nettype wire

/* tests/wed_fetch_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wed_layout.svh"

module wed_fetch_assert (
  input  logic                                   clock,
  input  logic                                   rstn,
  input  logic                                   enable,
  input  logic [wed_pkg::addr_width-1:0]         wed_address,
  input  logic                                   command_req,
  input  wed_pkg::command_code                   cmd_code,
  input  logic [wed_pkg::addr_width-1:0]         command_address,
  input  logic [wed_pkg::tag_width-1:0]          command_tag,
  input  logic [wed_pkg::size_width-1:0]         command_size,
  input  logic                                   command_ack,
  input  logic                                   beat_valid,
  input  logic [wed_pkg::tag_width-1:0]          beat_tag,
  input  logic [wed_pkg::index_width-1:0]        beat_index,
  input  logic [wed_pkg::beat_width-1:0]         beat_data,
  input  logic                                   response_valid,
  input  logic [wed_pkg::tag_width-1:0]          response_tag,
  input  wed_pkg::response_code                  rsp_code,
  input  logic                                   wed_req,
  input  logic                                   wed_ack,
  input  wed_pkg::wed_error                      wed_error_code,
  input  logic [wed_pkg::status_width-1:0]       wed_status,
  input  logic [wed_pkg::vertex_count_width-1:0] wed_vertex_count,
  input  logic [wed_pkg::edge_count_width-1:0]   wed_edge_count,
  input  logic [wed_pkg::vertex_array_width-1:0] wed_vertex_array,
  input  logic [wed_pkg::edge_array_width-1:0]   wed_edge_array,
  input  logic [wed_pkg::result_array_width-1:0] wed_result_array,
  input  logic                                   wed_released
);

  import wed_pkg::*;

  int unsigned           failures = 0;  // Failed assertions so far
  logic [beat_width-1:0] expected_header;
  logic                  expected_failed;
  logic                  line_answered;  // Matching response seen
  logic [383:0]          expected_fields;
  logic [383:0]          seen_fields;
  wed_error              expected_error;

  // Header beat and outcome as the host sent them
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      expected_header <= '0;
      expected_failed <= 1'b0;
      line_answered   <= 1'b0;
    end else begin
      if (beat_valid && (beat_tag == wed_tag) && (beat_index == '0)) begin
        expected_header <= beat_data;
      end
      if (response_valid && (response_tag == wed_tag)) begin
        expected_failed <= (rsp_code != done);
        line_answered   <= 1'b1;
      end else if (wed_released) begin
        line_answered   <= 1'b0;
      end
    end
  end

  always_comb begin
    expected_fields = {expected_header[`WED_STATUS_OFFSET +: 64],
                       expected_header[`WED_VERTEX_COUNT_OFFSET +: 64],
                       expected_header[`WED_EDGE_COUNT_OFFSET +: 64],
                       expected_header[`WED_VERTEX_ARRAY_OFFSET +: 64],
                       expected_header[`WED_EDGE_ARRAY_OFFSET +: 64],
                       expected_header[`WED_RESULT_ARRAY_OFFSET +: 64]};
    if (expected_failed) begin
      expected_error  = err_response;
      expected_fields = '0;  // Failed read carries nothing
    end else if ((expected_header[`WED_VERTEX_ARRAY_OFFSET +: 7] != '0) ||
                 (expected_header[`WED_EDGE_ARRAY_OFFSET +: 7] != '0) ||
                 (expected_header[`WED_RESULT_ARRAY_OFFSET +: 7] != '0)) begin
      expected_error = err_align;
    end else if (expected_header[`WED_VERTEX_COUNT_OFFSET +: 64] == '0) begin
      expected_error = err_empty;
    end else begin
      expected_error = err_none;
    end
  end

  assign seen_fields = {wed_status, wed_vertex_count, wed_edge_count,
                        wed_vertex_array, wed_edge_array, wed_result_array};

  reset_quiet: assert property (@(posedge clock) !rstn |-> !command_req && !wed_req)
    else begin
      failures++;
      $error("command_req or wed_req high in reset");
    end

  command_fields: assert property (@(posedge clock) disable iff (!rstn)
    command_req |-> (cmd_code == read_cl_na) && (command_address == wed_address) &&
                    (command_tag == wed_tag) && (command_size == 12'd128))
    else begin
      failures++;
      $error("Mismatch command_code/address/tag/size got %h %h %h %h expected %h %h %h %h",
             cmd_code, command_address, command_tag, command_size,
             read_cl_na, wed_address, wed_tag, 12'd128);
    end

  command_stable: assert property (@(posedge clock) disable iff (!rstn)
    command_req && !command_ack |=> command_req && $stable(cmd_code) &&
      $stable(command_address) && $stable(command_tag) && $stable(command_size))
    else begin
      failures++;
      $error("command_req or its fields changed before ack");
    end

  command_drop: assert property (@(posedge clock) disable iff (!rstn)
    command_req && command_ack |=> !command_req)
    else begin
      failures++;
      $error("command_req stayed high after ack");
    end

  command_rise: assert property (@(posedge clock) disable iff (!rstn)
    $rose(command_req) |-> !command_ack)
    else begin
      failures++;
      $error("command_req rose while ack was still high");
    end

  consumer_stable: assert property (@(posedge clock) disable iff (!rstn)
    wed_req && !wed_ack |=> wed_req && $stable(seen_fields) && $stable(wed_error_code))
    else begin
      failures++;
      $error("wed_req or descriptor changed before ack");
    end

  consumer_drop: assert property (@(posedge clock) disable iff (!rstn)
    wed_req && wed_ack |=> !wed_req)
    else begin
      failures++;
      $error("wed_req stayed high after ack");
    end

  error_value: assert property (@(posedge clock) disable iff (!rstn)
    $rose(wed_req) |-> wed_error_code == expected_error)
    else begin
      failures++;
      $error("Mismatch wed_error_code expected %h got %h", expected_error, wed_error_code);
    end

  field_values: assert property (@(posedge clock) disable iff (!rstn)
    $rose(wed_req) |-> seen_fields == expected_fields)
    else begin
      failures++;
      $error("Mismatch descriptor fields expected %h got %h", expected_fields, seen_fields);
    end

  answered_first: assert property (@(posedge clock) disable iff (!rstn)
    $rose(wed_req) |-> line_answered)
    else begin
      failures++;
      $error("wed_req rose without a matching response");
    end

  back_pressure: assert property (@(posedge clock) disable iff (!rstn)
    wed_req |-> !command_req)
    else begin
      failures++;
      $error("New command issued while descriptor still held");
    end

  refetch: assert property (@(posedge clock) disable iff (!rstn)
    wed_released && enable |-> ##2 command_req)
    else begin
      failures++;
      $error("No new fetch after the descriptor was released");
    end

endmodule

bind wed_fetch_top wed_fetch_assert checks0 (
  .clock            (clock),
  .rstn             (rstn),
  .enable           (enable),
  .wed_address      (wed_address),
  .command_req      (command_req),
  .cmd_code         (command_code),
  .command_address  (command_address),
  .command_tag      (command_tag),
  .command_size     (command_size),
  .command_ack      (command_ack),
  .beat_valid       (beat_valid),
  .beat_tag         (beat_tag),
  .beat_index       (beat_index),
  .beat_data        (beat_data),
  .response_valid   (response_valid),
  .response_tag     (response_tag),
  .rsp_code         (response_code),
  .wed_req          (wed_req),
  .wed_ack          (wed_ack),
  .wed_error_code   (wed_error_code),
  .wed_status       (wed_status),
  .wed_vertex_count (wed_vertex_count),
  .wed_edge_count   (wed_edge_count),
  .wed_vertex_array (wed_vertex_array),
  .wed_edge_array   (wed_edge_array),
  .wed_result_array (wed_result_array),
  .wed_released     (wed_released)
);

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real period = 8.0,
  parameter int  reset_cycles = 8
) (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #(period / 2.0) clock = ~clock;
  end

  initial begin
    rstn = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

/* tests/wed_fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wed_layout.svh"

module wed_fetch_tb;

  import wed_pkg::*;

  localparam int timeout_cycles = 300;
  localparam int fetch_count = 10;
  localparam logic [tag_width-1:0] foreign_tag = 8'h13;

  logic                          clock;
  logic                          rstn;
  logic                          enable;
  logic [addr_width-1:0]         wed_address;
  logic                          command_req;
  command_code                   cmd_code;
  logic [addr_width-1:0]         command_address;
  logic [tag_width-1:0]          command_tag;
  logic [size_width-1:0]         command_size;
  logic                          command_ack;
  logic                          beat_valid;
  logic [tag_width-1:0]          beat_tag;
  logic [index_width-1:0]        beat_index;
  logic [beat_width-1:0]         beat_data;
  logic                          response_valid;
  logic [tag_width-1:0]          response_tag;
  response_code                  rsp_code;
  logic                          wed_req;
  logic                          wed_ack;
  wed_error                      wed_error_code;
  logic [63:0]                   wed_status;
  logic [63:0]                   wed_vertex_count;
  logic [63:0]                   wed_edge_count;
  logic [63:0]                   wed_vertex_array;
  logic [63:0]                   wed_edge_array;
  logic [63:0]                   wed_result_array;
  integer                        seed;

  tb_clock #(.period(8.0), .reset_cycles(8)) clock0 (.clock(clock), .rstn(rstn));

  wed_fetch_top dut0 (
    .clock(clock), .rstn(rstn), .enable(enable), .wed_address(wed_address),
    .command_req(command_req), .command_code(cmd_code),
    .command_address(command_address), .command_tag(command_tag),
    .command_size(command_size), .command_ack(command_ack),
    .beat_valid(beat_valid), .beat_tag(beat_tag), .beat_index(beat_index),
    .beat_data(beat_data), .response_valid(response_valid),
    .response_tag(response_tag), .response_code(rsp_code),
    .wed_req(wed_req), .wed_ack(wed_ack), .wed_error_code(wed_error_code),
    .wed_status(wed_status), .wed_vertex_count(wed_vertex_count),
    .wed_edge_count(wed_edge_count), .wed_vertex_array(wed_vertex_array),
    .wed_edge_array(wed_edge_array), .wed_result_array(wed_result_array)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped");
  endtask

  // Any checker hit ends the run at once
  always @(posedge clock) begin
    if (dut0.checks0.failures != 0) fail_run("A checker assertion failed");
  end

  function automatic int pick_below(input int limit);
    return int'($unsigned($random(seed)) % limit);
  endfunction

  function automatic logic [beat_width-1:0] random_beat();
    logic [beat_width-1:0] value;
    for (int i = 0; i < beat_width / 32; i++) begin
      value[i*32 +: 32] = $random(seed);
    end
    return value;
  endfunction

  task automatic wait_command_req(input logic level);
    int count;
    count = 0;
    while (command_req !== level) begin
      @(negedge clock);
      count++;
      if (count > timeout_cycles) fail_run("Timed out waiting for command_req to change");
    end
  endtask

  task automatic wait_wed_req(input logic level);
    int count;
    count = 0;
    while (wed_req !== level) begin
      @(negedge clock);
      count++;
      if (count > timeout_cycles) fail_run("Timed out waiting for wed_req to change");
    end
  endtask

  task automatic send_beat(input logic [tag_width-1:0] tag, input int index,
                           input logic [beat_width-1:0] data);
    @(posedge clock);
    beat_valid <= 1'b1;
    beat_tag   <= tag;
    beat_index <= index_width'(index);
    beat_data  <= data;
    @(posedge clock);
    beat_valid <= 1'b0;
  endtask

  task automatic send_response(input logic [tag_width-1:0] tag, input response_code code);
    @(posedge clock);
    response_valid <= 1'b1;
    response_tag   <= tag;
    rsp_code       <= code;
    @(posedge clock);
    response_valid <= 1'b0;
  endtask

  // Kind 0 good, 1 failed, 2 misaligned, 3 empty, 4 foreign response first
  task automatic serve_fetch(input int kind);
    logic [beat_width-1:0] header;
    logic [beat_width-1:0] tail;
    int                    order [$];
    int                    pick;
    header = random_beat();
    tail   = random_beat();
    header[`WED_VERTEX_ARRAY_OFFSET +: 7] = '0;
    header[`WED_EDGE_ARRAY_OFFSET +: 7]   = '0;
    header[`WED_RESULT_ARRAY_OFFSET +: 7] = '0;
    header[`WED_VERTEX_COUNT_OFFSET]      = 1'b1;  // Never empty by chance
    if (kind == 2) header[`WED_EDGE_ARRAY_OFFSET + 3] = 1'b1;
    if (kind == 3) header[`WED_VERTEX_COUNT_OFFSET +: 64] = '0;
    wait_command_req(1'b1);
    repeat (pick_below(5)) @(posedge clock);
    @(posedge clock);
    command_ack <= 1'b1;
    wait_command_req(1'b0);
    repeat (pick_below(3)) @(posedge clock);
    @(posedge clock);
    command_ack <= 1'b0;
    order = '{0, 1, 2, 3, 4};
    while (order.size() > 0) begin
      pick = pick_below(order.size());
      case (order[pick])
        0: send_beat(wed_tag, 0, header);
        1: send_beat(wed_tag, 1, tail);
        2: send_beat(foreign_tag, 0, random_beat());
        3: send_beat(foreign_tag, 1, random_beat());
        default: send_beat(wed_tag, 5, random_beat());  // Out of range slot
      endcase
      order.delete(pick);
    end
    if (kind == 4) begin
      send_response(foreign_tag, done);
      repeat (6) @(posedge clock);
    end
    send_response(wed_tag, (kind == 1) ? failed : done);
  endtask

  task automatic take_descriptor(input logic last);
    wait_wed_req(1'b1);
    @(posedge clock);
    wed_address <= {$random(seed), $random(seed)} & ~64'h7f;
    if (last) enable <= 1'b0;
    repeat (pick_below(8)) @(posedge clock);  // Slow consumer
    @(posedge clock);
    wed_ack <= 1'b1;
    wait_wed_req(1'b0);
    @(posedge clock);
    wed_ack <= 1'b0;
  endtask

  initial begin
    int count;
    seed           = 32'h7866;
    enable         = 1'b0;
    wed_address    = 64'h0000_1000_0000_0080;
    command_ack    = 1'b0;
    beat_valid     = 1'b0;
    beat_tag       = '0;
    beat_index     = '0;
    beat_data      = '0;
    response_valid = 1'b0;
    response_tag   = '0;
    rsp_code       = done;
    wed_ack        = 1'b0;
    count          = 0;
    while (rstn !== 1'b1) begin
      @(negedge clock);
      count++;
      if (count > timeout_cycles) fail_run("Timed out waiting for reset release");
    end
    @(posedge clock);
    enable <= 1'b1;
    for (int i = 0; i < fetch_count; i++) begin
      serve_fetch(i % 5);
      take_descriptor(i == fetch_count - 1);
    end
    repeat (6) @(negedge clock);
    if (dut0.checks0.failures == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_run("Checker reported failures");
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
logic/wed_pkg.sv
logic/wed_control.sv
logic/wed_decode.sv
logic/wed_result.sv
logic/wed_fetch_top.sv
tests/wed_fetch_assert.sv
tests/tb_clock.sv
tests/wed_fetch_tb.sv

/* Makefile */
TOP = wed_fetch_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f \
	  --Mdir $(OBJ) -o V$(TOP)

# Errors are counted by the checker, the testbench ends the run
run: compile
	./$(OBJ)/V$(TOP) +verilator+error+limit+1000

clean:
	rm -rf $(OBJ)
